// File: files.f
+incdir+common
common/hps_pkg.sv
verilog/hps_cmd_decode.sv
verilog/hps_input_regs.sv
verilog/hps_readback.sv
download/hps_download.sv
verilog/hps_io_top.sv
testbench/tb_hps_io.sv

// File: Makefile
# Verilator build and run for the host command port testbench

VERILATOR ?= verilator
TOP       ?= tb_hps_io
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  := *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/tb_hps_io.sv
`timescale 1ns/1ps
`include "hps_params.svh"

module tb_hps_io;

	import hps_pkg::*;

	// every output the DUT shows in one cycle
	typedef struct packed {
		logic [15:0] dout;
		hps_cfg_t    cfg;
		logic [31:0] joy0;
		logic [31:0] joy1;
		logic [63:0] status;
		hps_ioctl_t  ioctl;
	} expect_t;

	localparam int num_trans  = 60;
	localparam int max_cycles = num_trans * 12 * 2;

	logic                     clk_sys;
	logic                     reset;
	hps_bus_t                 bus;
	logic                     ioctl_wait;
	logic [15:0]              joy_raw;
	logic [8*`HPS_STRLEN-1:0] conf_str;
	logic [63:0]              status_in;
	logic                     status_set;
	logic [15:0]              io_dout;
	logic                     io_wait;
	hps_cfg_t                 cfg;
	logic [31:0]              joystick_0;
	logic [31:0]              joystick_1;
	logic [63:0]              status;
	hps_ioctl_t               ioctl;

	integer seed        = 32'he0e3;
	int     cycle_count = 0;
	string  conf_text   = "HPS_IO;TEST_CORE";

	// reference model state
	hps_cmd_e               m_cmd;
	logic [`HPS_CNT_W-1:0]  m_idx;
	logic [`HPS_ADDR_W-1:0] m_addr;
	logic [3:0]             m_req_cnt;
	logic [63:0]            m_cap;
	logic                   m_set_old;
	expect_t                m_out;
	// expectations for the two cycles still in the DUT pipeline
	expect_t                hist1;
	expect_t                hist2;
	logic                   drv_set;
	logic [63:0]            drv_sin;
	logic [15:0]            drv_joy_raw;
	logic [15:0]            payload_q[$];

	hps_io_top i_dut (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (bus),
		.io_dout    (io_dout),
		.io_wait    (io_wait),
		.ioctl_wait (ioctl_wait),
		.joy_raw    (joy_raw),
		.conf_str   (conf_str),
		.status_in  (status_in),
		.status_set (status_set),
		.cfg        (cfg),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.ioctl      (ioctl)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("*** FAILED ***");
			$fatal(1, "timeout");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_on_error(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		$display("*** FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string what, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("%s is %h, expected %h", what, got, exp));
		end
	endtask

	task automatic check_cfg(input hps_cfg_t got, input hps_cfg_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("cfg is %h, expected %h", got, exp));
		end
	endtask

	task automatic check_joystick(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("%s is %h, expected %h", what, got, exp));
		end
	endtask

	task automatic check_status(input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("status is %h, expected %h", got, exp));
		end
	endtask

	task automatic check_ioctl(input hps_ioctl_t got, input hps_ioctl_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("ioctl is %h, expected %h", got, exp));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic hps_cmd_e known_cmd(input logic [15:0] w);
		case (w)
			16'h0001: return CMD_CFG;
			16'h0002: return CMD_JOY0;
			16'h0003: return CMD_JOY1;
			16'h000F: return CMD_JOY_RAW;
			16'h0014: return CMD_CONF_STR;
			16'h001E: return CMD_STATUS;
			16'h0029: return CMD_STATUS_REQ;
			16'h0053: return CMD_FILE_TX;
			16'h0054: return CMD_FILE_TX_DAT;
			16'h0055: return CMD_FILE_INDEX;
			default: return CMD_NONE;
		endcase
	endfunction

	task automatic apply_record(input logic [15:0] d);
		int k;
		k = m_idx;
		m_out.dout = 16'h0000;
		if (m_cmd == CMD_STATUS_REQ && k == 0)
			m_out.dout = 16'h00A0 + m_req_cnt;
		else if (m_cmd == CMD_STATUS_REQ && k <= 4)
			m_out.dout = m_cap[16*(k-1) +: 16];
		else if (m_cmd == CMD_JOY_RAW && k != 0)
			m_out.dout = drv_joy_raw;
		else if (m_cmd == CMD_CONF_STR && k != 0 && k <= `HPS_STRLEN)
			m_out.dout = {8'h00, conf_text[k-1]};
		// writes come from payload words only
		if (k != 0) begin
			case (m_cmd)
				CMD_CFG: begin
					m_out.cfg.buttons            = d[1:0];
					m_out.cfg.forced_scandoubler = d[4];
					m_out.cfg.direct_video       = d[10];
				end
				CMD_JOY0: begin
					if (k == 1)
						m_out.joy0[15:0] = d;
					else
						m_out.joy0[31:16] = d;
				end
				CMD_JOY1: begin
					if (k == 1)
						m_out.joy1[15:0] = d;
					else
						m_out.joy1[31:16] = d;
				end
				CMD_STATUS: begin
					if (k <= 4)
						m_out.status[16*(k-1) +: 16] = d;
				end
				CMD_FILE_INDEX: m_out.ioctl.index = d[7:0];
				CMD_FILE_TX: begin
					m_out.ioctl.download = (d[7:0] != 8'h00);
					if (d[7:0] != 8'h00)
						m_addr = '0;
					else
						m_out.ioctl.addr = m_addr;
				end
				CMD_FILE_TX_DAT: begin
					m_out.ioctl.addr = m_addr;
					m_out.ioctl.dout = d[7:0];
					m_out.ioctl.wr   = 1'b1;
					m_addr           = m_addr + 1'b1;
				end
				default: ;
			endcase
		end
	endtask

	task automatic step_model(input logic en, input logic stb, input logic [15:0] din);
		m_out.ioctl.wr = 1'b0;
		if (drv_set && !m_set_old) begin
			m_req_cnt = m_req_cnt + 1'b1;
			m_cap     = drv_sin;
		end
		m_set_old = drv_set;
		if (!en) begin
			m_idx      = '0;
			m_cmd      = CMD_NONE;
			m_out.dout = 16'h0000;
		end else if (stb) begin
			if (m_idx == '0)
				m_cmd = known_cmd(din);
			apply_record(din);
			if (m_idx != '1)
				m_idx = m_idx + 1'b1;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	// one clock of bus activity, outputs checked against the model two cycles back
	task automatic cycle(input logic en, input logic stb, input logic [15:0] din);
		expect_t     now_s;
		logic [31:0] r;
		logic        drv_wait;
		@(posedge clk_sys);
		r = $random(seed);
		if (r[3:0] == 4'h0)
			drv_set = ~drv_set;
		drv_sin  = {$random(seed), $random(seed)};
		drv_wait = r[8];
		bus        <= '{enable: en, strobe: stb, din: din};
		status_set <= drv_set;
		status_in  <= drv_sin;
		ioctl_wait <= drv_wait;
		joy_raw    <= drv_joy_raw;
		step_model(en, stb, din);
		now_s = m_out;
		@(negedge clk_sys);
		check_word("io_wait", {15'h0000, io_wait}, {15'h0000, drv_wait});
		check_word("io_dout", io_dout, hist2.dout);
		check_cfg(cfg, hist2.cfg);
		check_joystick("joystick_0", joystick_0, hist2.joy0);
		check_joystick("joystick_1", joystick_1, hist2.joy1);
		check_status(status, hist2.status);
		check_ioctl(ioctl, hist2.ioctl);
		hist2 = hist1;
		hist1 = now_s;
	endtask

	task automatic insert_gap();
		logic [31:0] r;
		int          gap;
		r   = $random(seed);
		gap = (r[1:0] == 2'd3) ? 0 : r[1:0];
		repeat (gap) begin
			r = $random(seed);
			cycle(1'b1, 1'b0, r[15:0]);
		end
	endtask

	task automatic fill_payload(input int n);
		logic [31:0] r;
		repeat (n) begin
			r = $random(seed);
			payload_q.push_back(r[15:0]);
		end
	endtask

	function automatic int payload_len();
		logic [31:0] r;
		r = $random(seed);
		return 1 + (r % 6);
	endfunction

	task automatic send_transaction(input logic [15:0] cmd_word);
		logic [31:0] r;
		cycle(1'b1, 1'b1, cmd_word);
		insert_gap();
		foreach (payload_q[i]) begin
			cycle(1'b1, 1'b1, payload_q[i]);
			insert_gap();
		end
		cycle(1'b0, 1'b0, 16'h0000);
		// raw joystick only moves while no transfer can read it
		r           = $random(seed);
		drv_joy_raw = r[15:0];
		cycle(1'b0, 1'b0, 16'h0000);
		payload_q.delete();
	endtask

	task automatic run_download();
		logic [31:0] r;
		r = $random(seed);
		payload_q.push_back(r[15:0]);
		send_transaction(CMD_FILE_INDEX);
		r = $random(seed);
		payload_q.push_back({r[15:8], r[7:0] | 8'h01});
		send_transaction(CMD_FILE_TX);
		fill_payload(payload_len());
		send_transaction(CMD_FILE_TX_DAT);
		r = $random(seed);
		payload_q.push_back({r[15:8], 8'h00});
		send_transaction(CMD_FILE_TX);
	endtask

	initial begin
		logic [31:0] r;
		reset       = 1'b1;
		bus         = '0;
		ioctl_wait  = 1'b0;
		joy_raw     = 16'h0000;
		status_in   = '0;
		status_set  = 1'b0;
		conf_str    = "HPS_IO;TEST_CORE";
		drv_set     = 1'b0;
		drv_sin     = '0;
		drv_joy_raw = 16'h0000;
		m_cmd       = CMD_NONE;
		m_idx       = '0;
		m_addr      = '0;
		m_req_cnt   = '0;
		m_cap       = '0;
		m_set_old   = 1'b0;
		m_out       = '0;
		hist1       = '0;
		hist2       = '0;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		for (int t = 0; t < num_trans; t++) begin
			r = $random(seed);
			case (r % 9)
				0: begin
					fill_payload(payload_len());
					send_transaction(CMD_CFG);
				end
				1: begin
					fill_payload(payload_len());
					send_transaction(CMD_JOY0);
				end
				2: begin
					fill_payload(payload_len());
					send_transaction(CMD_JOY1);
				end
				3: begin
					fill_payload(payload_len());
					send_transaction(CMD_STATUS);
				end
				4: begin
					fill_payload(payload_len());
					send_transaction(CMD_STATUS_REQ);
				end
				5: begin
					fill_payload(`HPS_STRLEN + 2);
					send_transaction(CMD_CONF_STR);
				end
				6: begin
					fill_payload(payload_len());
					send_transaction(CMD_JOY_RAW);
				end
				7: run_download();
				default: begin
					// unknown opcode, must leave every output alone
					r = $random(seed);
					while (known_cmd(r[15:0]) != CMD_NONE)
						r = $random(seed);
					fill_payload(payload_len());
					send_transaction(r[15:0]);
				end
			endcase
		end
		// flush the last two cycles of expectations
		repeat (3) cycle(1'b0, 1'b0, 16'h0000);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: verilog/hps_io_top.sv
`timescale 1ns/1ps
`include "hps_params.svh"

module hps_io_top (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  hps_pkg::hps_bus_t         bus,
	output logic [15:0]               io_dout,
	output logic                      io_wait,
	input  logic                      ioctl_wait,
	input  logic [15:0]               joy_raw,
	input  logic [8*`HPS_STRLEN-1:0]  conf_str,
	input  logic [63:0]               status_in,
	input  logic                      status_set,
	output hps_pkg::hps_cfg_t         cfg,
	output logic [31:0]               joystick_0,
	output logic [31:0]               joystick_1,
	output logic [63:0]               status,
	output hps_pkg::hps_ioctl_t       ioctl
);

	import hps_pkg::*;

	hps_word_t word;

	// host wait comes straight from the core
	assign io_wait = ioctl_wait;

	hps_cmd_decode i_decode (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (bus),
		.word       (word)
	);

	hps_input_regs i_input_regs (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.word       (word),
		.cfg        (cfg),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status)
	);

	hps_readback i_readback (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.word       (word),
		.joy_raw    (joy_raw),
		.conf_str   (conf_str),
		.status_in  (status_in),
		.status_set (status_set),
		.io_dout    (io_dout)
	);

	hps_download i_download (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.word       (word),
		.ioctl      (ioctl)
	);

endmodule

// File: download/hps_download.sv
`timescale 1ns/1ps
`include "hps_params.svh"

module hps_download (
	input  logic                clk_sys,
	input  logic                reset,
	input  hps_pkg::hps_word_t  word,
	output hps_pkg::hps_ioctl_t ioctl
);

	import hps_pkg::*;

	logic [`HPS_ADDR_W-1:0] addr;
	logic                   payload;

	assign payload = word.valid && !word.first;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ioctl <= '0;
			addr  <= '0;
		end else begin
			// write strobe is a single cycle
			ioctl.wr <= 1'b0;
			if (payload) begin
				case (word.cmd)
					CMD_FILE_INDEX: begin
						ioctl.index <= word.data[7:0];
					end
					CMD_FILE_TX: begin
						if (word.data[7:0] != 8'h00) begin
							addr           <= '0;
							ioctl.download <= 1'b1;
						end else begin
							// leave the byte count visible after the stop
							ioctl.addr     <= addr;
							ioctl.download <= 1'b0;
						end
					end
					CMD_FILE_TX_DAT: begin
						ioctl.addr <= addr;
						ioctl.dout <= word.data[7:0];
						ioctl.wr   <= 1'b1;
						addr       <= addr + 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// File: verilog/hps_readback.sv
`timescale 1ns/1ps
`include "hps_params.svh"

module hps_readback (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  hps_pkg::hps_word_t        word,
	input  logic [15:0]               joy_raw,
	input  logic [8*`HPS_STRLEN-1:0]  conf_str,
	input  logic [63:0]               status_in,
	input  logic                      status_set,
	output logic [15:0]               io_dout
);

	import hps_pkg::*;

	logic        old_status_set;
	logic [3:0]  req_cnt;
	logic [63:0] status_req;

	// core status-set request, counted on the rising edge
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_status_set <= 1'b0;
			req_cnt        <= '0;
		end else begin
			old_status_set <= status_set;
			if (status_set && !old_status_set)
				req_cnt <= req_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			status_req <= '0;
		end else if (status_set && !old_status_set) begin
			status_req <= status_in;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// read word towards the host
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			io_dout <= '0;
		end else if (word.valid) begin
			io_dout <= '0;
			case (word.cmd)
				CMD_STATUS_REQ: begin
					case (word.index)
						0: io_dout <= {8'h00, 4'hA, req_cnt};
						1: io_dout <= status_req[15:0];
						2: io_dout <= status_req[31:16];
						3: io_dout <= status_req[47:32];
						4: io_dout <= status_req[63:48];
						default: ;
					endcase
				end
				CMD_JOY_RAW: begin
					if (!word.first)
						io_dout <= joy_raw;
				end
				// character 1 sits in the top byte of the string
				CMD_CONF_STR: begin
					if (word.index != '0 && word.index <= `HPS_STRLEN)
						io_dout[7:0] <= conf_str[8*(`HPS_STRLEN - word.index) +: 8];
				end
				default: ;
			endcase
		end else if (!word.first && word.index == '0) begin
			// enable dropped
			io_dout <= '0;
		end
	end

endmodule

// File: verilog/hps_input_regs.sv
`timescale 1ns/1ps

module hps_input_regs (
	input  logic               clk_sys,
	input  logic               reset,
	input  hps_pkg::hps_word_t word,
	output hps_pkg::hps_cfg_t  cfg,
	output logic [31:0]        joystick_0,
	output logic [31:0]        joystick_1,
	output logic [63:0]        status
);

	import hps_pkg::*;

	logic payload;

	// payload words only, the command word itself writes nothing
	assign payload = word.valid && !word.first;

	////////////////////////////////////////////////////////////////////////////
	// configuration word and digital joysticks
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
		end else if (payload) begin
			case (word.cmd)
				CMD_CFG: begin
					cfg.buttons            <= word.data[1:0];
					cfg.forced_scandoubler <= word.data[4];
					cfg.direct_video       <= word.data[10];
				end
				// low half first, every later word lands in the high half
				CMD_JOY0: begin
					if (word.index == 1)
						joystick_0[15:0] <= word.data;
					else
						joystick_0[31:16] <= word.data;
				end
				CMD_JOY1: begin
					if (word.index == 1)
						joystick_1[15:0] <= word.data;
					else
						joystick_1[31:16] <= word.data;
				end
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// 64-bit status, four words lowest first
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			status <= '0;
		end else if (payload && word.cmd == CMD_STATUS) begin
			case (word.index)
				1: status[15:0]  <= word.data;
				2: status[31:16] <= word.data;
				3: status[47:32] <= word.data;
				4: status[63:48] <= word.data;
				// extra words are dropped
				default: ;
			endcase
		end
	end

endmodule

// File: verilog/hps_cmd_decode.sv
`timescale 1ns/1ps
`include "hps_params.svh"

module hps_cmd_decode (
	input  logic              clk_sys,
	input  logic              reset,
	input  hps_pkg::hps_bus_t bus,
	output hps_pkg::hps_word_t word
);

	import hps_pkg::*;

	hps_cmd_e              cmd_q;
	logic [`HPS_CNT_W-1:0] cnt;

	// only known opcodes pass, anything else is ignored downstream
	function automatic hps_cmd_e decode_cmd(input logic [15:0] din);
		hps_cmd_e c;
		c = hps_cmd_e'(din);
		case (c)
			CMD_CFG, CMD_JOY0, CMD_JOY1, CMD_JOY_RAW, CMD_CONF_STR,
			CMD_STATUS, CMD_STATUS_REQ, CMD_FILE_TX, CMD_FILE_TX_DAT,
			CMD_FILE_INDEX: decode_cmd = c;
			default: decode_cmd = CMD_NONE;
		endcase
	endfunction

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cmd_q <= CMD_NONE;
			cnt   <= '0;
			word  <= '0;
		end else if (!bus.enable) begin
			// all-zero record marks the end of a transfer
			cmd_q <= CMD_NONE;
			cnt   <= '0;
			word  <= '0;
		end else if (bus.strobe) begin
			word.valid <= 1'b1;
			word.data  <= bus.din;
			word.index <= cnt;
			if (cnt == '0) begin
				word.first <= 1'b1;
				word.cmd   <= decode_cmd(bus.din);
				cmd_q      <= decode_cmd(bus.din);
			end else begin
				word.first <= 1'b0;
				word.cmd   <= cmd_q;
			end
			// saturate so long transfers keep the last index
			if (cnt != '1) begin
				cnt <= cnt + 1'b1;
			end
		end else begin
			// idle gap inside a transfer, the rest of the record holds
			word.valid <= 1'b0;
		end
	end

endmodule

// File: common/hps_pkg.sv
`include "hps_params.svh"

package hps_pkg;

	// host opcodes, first word of every transfer
	typedef enum logic [15:0] {
		CMD_NONE        = 16'h0000,
		CMD_CFG         = 16'h0001,
		CMD_JOY0        = 16'h0002,
		CMD_JOY1        = 16'h0003,
		CMD_JOY_RAW     = 16'h000F,
		CMD_CONF_STR    = 16'h0014,
		CMD_STATUS      = 16'h001E,
		CMD_STATUS_REQ  = 16'h0029,
		CMD_FILE_TX     = 16'h0053,
		CMD_FILE_TX_DAT = 16'h0054,
		CMD_FILE_INDEX  = 16'h0055
	} hps_cmd_e;

	// host bus inputs
	typedef struct packed {
		logic        enable;
		logic        strobe;
		logic [15:0] din;
	} hps_bus_t;

	// one decoded bus word, command word has first set and index 0
	typedef struct packed {
		logic                    valid;
		logic                    first;
		hps_cmd_e                cmd;
		logic [`HPS_CNT_W-1:0]   index;
		logic [15:0]             data;
	} hps_word_t;

	// file download outputs towards the core
	typedef struct packed {
		logic                    download;
		logic                    wr;
		logic [7:0]              index;
		logic [`HPS_ADDR_W-1:0]  addr;
		logic [7:0]              dout;
	} hps_ioctl_t;

	// config word bits 1:0, 4 and 10
	typedef struct packed {
		logic [1:0] buttons;
		logic       forced_scandoubler;
		logic       direct_video;
	} hps_cfg_t;

endpackage

// File: common/hps_params.svh
`ifndef HPS_PARAMS_SVH
`define HPS_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// host command port sizes
////////////////////////////////////////////////////////////////////////////

// configuration string length in bytes
`define HPS_STRLEN 16

// download byte address width
`define HPS_ADDR_W 27

// payload word counter width, counter saturates at all ones
`define HPS_CNT_W 9

`endif
